// ==== source/lsb_pkg.sv ====
package lsb_pkg;

    localparam int LSB_DEPTH      = 16;
    localparam int LSB_FULL_LEVEL = 13;
    localparam int TAG_W          = 4;
    localparam int XLEN           = 32;
    localparam int BYTE_W         = 8;

    typedef logic [$clog2(LSB_DEPTH)-1:0] ptr_t;
    typedef logic [TAG_W-1:0]             tag_t;   // 0 = no dependency
    typedef logic [XLEN-1:0]              word_t;

    typedef enum logic [3:0] {
        OP_LB  = 4'd0,
        OP_LH  = 4'd1,
        OP_LW  = 4'd2,
        OP_LBU = 4'd3,
        OP_LHU = 4'd4,
        OP_SB  = 4'd5,
        OP_SH  = 4'd6,
        OP_SW  = 4'd7
    } mem_op_t;

    typedef enum logic [1:0] {
        EMPTY     = 2'd0,
        WAITING   = 2'd1,
        READY     = 2'd2,
        COMMITTED = 2'd3
    } entry_state_t;

    typedef struct packed {
        logic    valid;
        mem_op_t op;
        tag_t    tag;
        word_t   rs1_val;
        tag_t    rs1_tag;
        word_t   rs2_val;
        tag_t    rs2_tag;
        word_t   imm;
    } dispatch_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t value;
    } bcast_t;

    typedef struct packed {
        logic              valid;
        logic              write;
        word_t             addr;
        logic [BYTE_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic    go;     // head may execute now
        mem_op_t op;
        tag_t    tag;
        word_t   addr;
        word_t   sdata;
    } head_t;

    function automatic logic is_load(mem_op_t op);
        return op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    endfunction

    // index of the last byte touched by an op
    function automatic logic [1:0] op_last_byte(mem_op_t op);
        case (op)
            OP_LH, OP_LHU, OP_SH: return 2'd1;
            OP_LW, OP_SW:         return 2'd3;
            default:              return 2'd0;
        endcase
    endfunction

endpackage

// ==== source/operand_capture.sv ====
module operand_capture import lsb_pkg::*; (
    input  tag_t   wait_tag,
    input  bcast_t alu_bcast,
    input  bcast_t load_bcast,
    output logic   hit,
    output word_t  value
);

    logic pending;
    logic alu_hit;
    logic load_hit;

    assign pending = wait_tag != '0;   // tag 0 never matches

    assign alu_hit  = pending && alu_bcast.valid && (alu_bcast.tag == wait_tag);
    assign load_hit = pending && load_bcast.valid && (load_bcast.tag == wait_tag);

    assign hit = alu_hit || load_hit;

    // both buses never carry the same live tag
    always_comb begin
        if (alu_hit) begin
            value = alu_bcast.value;
        end else begin
            value = load_bcast.value;
        end
    end

endmodule

// ==== source/lsb_queue.sv ====
module lsb_queue import lsb_pkg::*; (
    input  logic      clk_in,
    input  logic      rst_in,
    input  dispatch_t disp,
    input  bcast_t    alu_bcast,
    input  bcast_t    load_bcast,
    input  logic      store_commit,
    input  logic      clear,
    input  logic      pop,
    output head_t     head,
    output logic      full
);

    entry_state_t state_q   [LSB_DEPTH];
    mem_op_t      op_q      [LSB_DEPTH];
    tag_t         tag_q     [LSB_DEPTH];
    word_t        rs1_val_q [LSB_DEPTH];
    tag_t         rs1_tag_q [LSB_DEPTH];
    word_t        rs2_val_q [LSB_DEPTH];
    tag_t         rs2_tag_q [LSB_DEPTH];
    word_t        imm_q     [LSB_DEPTH];

    ptr_t head_ptr;
    ptr_t rear_ptr;
    ptr_t commit_ptr;

    logic [$clog2(LSB_DEPTH):0] occ;
    logic [$clog2(LSB_DEPTH):0] n_commit;

    logic [LSB_DEPTH-1:0] rs1_hit;
    logic [LSB_DEPTH-1:0] rs2_hit;
    word_t                rs1_cap [LSB_DEPTH];
    word_t                rs2_cap [LSB_DEPTH];

    logic  disp_hit1;
    logic  disp_hit2;
    word_t disp_val1;
    word_t disp_val2;
    logic  disp_ok;
    logic  do_disp;

    entry_state_t head_state;

    // one capture pair per entry
    for (genvar g = 0; g < LSB_DEPTH; g++) begin : g_wake
        operand_capture i_cap_rs1 (
            .wait_tag   (rs1_tag_q[g]),
            .alu_bcast  (alu_bcast),
            .load_bcast (load_bcast),
            .hit        (rs1_hit[g]),
            .value      (rs1_cap[g])
        );
        operand_capture i_cap_rs2 (
            .wait_tag   (rs2_tag_q[g]),
            .alu_bcast  (alu_bcast),
            .load_bcast (load_bcast),
            .hit        (rs2_hit[g]),
            .value      (rs2_cap[g])
        );
    end

    // same-cycle bypass on the dispatch path
    operand_capture i_cap_disp_rs1 (
        .wait_tag   (disp.rs1_tag),
        .alu_bcast  (alu_bcast),
        .load_bcast (load_bcast),
        .hit        (disp_hit1),
        .value      (disp_val1)
    );

    operand_capture i_cap_disp_rs2 (
        .wait_tag   (disp.rs2_tag),
        .alu_bcast  (alu_bcast),
        .load_bcast (load_bcast),
        .hit        (disp_hit2),
        .value      (disp_val2)
    );

    always_comb begin
        occ      = '0;
        n_commit = '0;
        for (int i = 0; i < LSB_DEPTH; i++) begin
            if (state_q[i] != EMPTY) begin
                occ = occ + 1'b1;
            end
            if (state_q[i] == COMMITTED) begin
                n_commit = n_commit + 1'b1;
            end
        end
    end

    // committed stores sit contiguous from head
    assign rear_ptr   = head_ptr + ptr_t'(occ);
    assign commit_ptr = head_ptr + ptr_t'(n_commit);
    assign full       = occ >= LSB_FULL_LEVEL;

    assign do_disp = disp.valid && !clear;
    assign disp_ok = (disp.rs1_tag == '0 || disp_hit1) && (disp.rs2_tag == '0 || disp_hit2);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            head_ptr <= '0;
            for (int i = 0; i < LSB_DEPTH; i++) begin
                state_q[i] <= EMPTY;
            end
        end else begin
            for (int i = 0; i < LSB_DEPTH; i++) begin
                if (clear && state_q[i] != COMMITTED) begin
                    state_q[i] <= EMPTY;
                end else if (state_q[i] == WAITING &&
                             (rs1_tag_q[i] == '0 || rs1_hit[i]) &&
                             (rs2_tag_q[i] == '0 || rs2_hit[i])) begin
                    state_q[i] <= READY;
                end
            end
            if (store_commit && !clear) begin
                state_q[commit_ptr] <= COMMITTED;
            end
            if (do_disp) begin
                state_q[rear_ptr] <= disp_ok ? READY : WAITING;
            end
            if (pop) begin
                state_q[head_ptr] <= EMPTY;
                head_ptr          <= head_ptr + ptr_t'(1);
            end
        end
    end

    always_ff @(posedge clk_in) begin
        for (int i = 0; i < LSB_DEPTH; i++) begin
            if (rs1_hit[i]) begin
                rs1_val_q[i] <= rs1_cap[i];
                rs1_tag_q[i] <= '0;
            end
            if (rs2_hit[i]) begin
                rs2_val_q[i] <= rs2_cap[i];
                rs2_tag_q[i] <= '0;
            end
        end
        if (do_disp) begin   // overrides stale wakeup on the rear slot
            op_q[rear_ptr]      <= disp.op;
            tag_q[rear_ptr]     <= disp.tag;
            imm_q[rear_ptr]     <= disp.imm;
            rs1_val_q[rear_ptr] <= disp_hit1 ? disp_val1 : disp.rs1_val;
            rs1_tag_q[rear_ptr] <= disp_hit1 ? '0 : disp.rs1_tag;
            rs2_val_q[rear_ptr] <= disp_hit2 ? disp_val2 : disp.rs2_val;
            rs2_tag_q[rear_ptr] <= disp_hit2 ? '0 : disp.rs2_tag;
        end
    end

    assign head_state = state_q[head_ptr];

    always_comb begin
        head.op    = op_q[head_ptr];
        head.tag   = tag_q[head_ptr];
        head.addr  = rs1_val_q[head_ptr] + imm_q[head_ptr];
        head.sdata = rs2_val_q[head_ptr];
        // stores go only once committed and fully woken
        head.go    = (head_state == READY && is_load(op_q[head_ptr])) ||
                     (head_state == COMMITTED && !is_load(op_q[head_ptr]) &&
                      rs1_tag_q[head_ptr] == '0 && rs2_tag_q[head_ptr] == '0);
    end

endmodule

// ==== source/mem_sequencer.sv ====
module mem_sequencer import lsb_pkg::*; (
    input  logic              clk_in,
    input  logic              rst_in,
    input  head_t             head,
    input  logic              clear,
    input  logic [BYTE_W-1:0] mem_rdata,
    output mem_req_t          mem_req,
    output bcast_t            load_result,
    output logic              pop
);

    // issue side
    logic       active_q;   // more bytes after the first
    logic [1:0] idx_q;
    mem_op_t    op_q;
    tag_t       tag_q;
    word_t      addr_q;
    word_t      sdata_q;

    // read return side
    logic       rd_valid_q;
    logic [1:0] rd_idx_q;
    logic       rd_last_q;
    logic       res_valid_q;
    word_t      data_q;

    logic       busy;
    logic       start;
    logic       issue;
    mem_op_t    cur_op;
    word_t      cur_base;
    word_t      cur_sdata;
    logic [1:0] cur_idx;
    logic       cur_write;
    logic       cur_last;
    word_t      ext_data;

    // held through the result cycle so the old head can't restart
    assign busy  = active_q || rd_valid_q || res_valid_q;
    assign start = !busy && head.go;

    // first byte straight from head, rest from the latched copy
    always_comb begin
        if (active_q) begin
            cur_op    = op_q;
            cur_base  = addr_q;
            cur_sdata = sdata_q;
            cur_idx   = idx_q;
        end else begin
            cur_op    = head.op;
            cur_base  = head.addr;
            cur_sdata = head.sdata;
            cur_idx   = '0;
        end
    end

    assign cur_write = !is_load(cur_op);
    assign cur_last  = cur_idx == op_last_byte(cur_op);

    // a load dies on clear, a committed store runs on
    assign issue = (active_q || start) && (cur_write || !clear);

    always_comb begin
        mem_req.valid = issue;
        mem_req.write = cur_write;
        mem_req.addr  = cur_base + word_t'(cur_idx);
        mem_req.wdata = cur_sdata[BYTE_W*cur_idx +: BYTE_W];   // low byte first
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            active_q    <= 1'b0;
            rd_valid_q  <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            active_q    <= issue && !cur_last;
            rd_valid_q  <= issue && !cur_write;
            res_valid_q <= rd_valid_q && rd_last_q && !clear;
        end
    end

    always_ff @(posedge clk_in) begin
        if (start) begin
            op_q    <= head.op;
            tag_q   <= head.tag;
            addr_q  <= head.addr;
            sdata_q <= head.sdata;
        end
        if (issue) begin
            idx_q     <= cur_idx + 2'd1;
            rd_idx_q  <= cur_idx;    // byte lands next cycle
            rd_last_q <= cur_last;
        end
        if (rd_valid_q) begin
            data_q[BYTE_W*rd_idx_q +: BYTE_W] <= mem_rdata;
        end
    end

    always_comb begin
        case (op_q)
            OP_LB:   ext_data = {{(XLEN-BYTE_W){data_q[BYTE_W-1]}}, data_q[BYTE_W-1:0]};
            OP_LH:   ext_data = {{(XLEN-2*BYTE_W){data_q[2*BYTE_W-1]}},
                                 data_q[2*BYTE_W-1:0]};
            OP_LBU:  ext_data = {{(XLEN-BYTE_W){1'b0}}, data_q[BYTE_W-1:0]};
            OP_LHU:  ext_data = {{(XLEN-2*BYTE_W){1'b0}}, data_q[2*BYTE_W-1:0]};
            default: ext_data = data_q;   // lw
        endcase
    end

    always_comb begin
        load_result.valid = res_valid_q && !clear;
        load_result.tag   = tag_q;
        load_result.value = ext_data;
    end

    // store pops on its last write, load with its result
    assign pop = (issue && cur_write && cur_last) || (res_valid_q && !clear);

endmodule

// ==== source/lsb_top.sv ====
module lsb_top import lsb_pkg::*; (
    input  logic              clk_in,
    input  logic              rst_in,
    input  dispatch_t         disp,
    input  bcast_t            alu_bcast,
    input  logic              store_commit,
    input  logic              clear,
    input  logic [BYTE_W-1:0] mem_rdata,
    output mem_req_t          mem_req,
    output bcast_t            load_result,
    output logic              full
);

    head_t head;
    logic  pop;

    lsb_queue i_lsb_queue (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .disp         (disp),
        .alu_bcast    (alu_bcast),
        .load_bcast   (load_result),   // own result wakes dependents
        .store_commit (store_commit),
        .clear        (clear),
        .pop          (pop),
        .head         (head),
        .full         (full)
    );

    mem_sequencer i_mem_sequencer (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .head        (head),
        .clear       (clear),
        .mem_rdata   (mem_rdata),
        .mem_req     (mem_req),
        .load_result (load_result),
        .pop         (pop)
    );

endmodule

// ==== sim/lsb_assert.sv ====
module lsb_assert import lsb_pkg::*; (
    input logic     clk_in,
    input logic     rst_in,
    input mem_req_t mem_req,
    input bcast_t   load_result,
    input logic     full
);

    // quiet once the first reset edge has landed
    property p_reset_quiet;
        @(posedge clk_in) rst_in && $past(rst_in) |->
            !mem_req.valid && !load_result.valid && !full;
    endproperty

    property p_result_tag;
        @(posedge clk_in) disable iff (rst_in)
            load_result.valid |-> load_result.tag != '0;
    endproperty

    // sequencer stays idle in a load's result cycle
    property p_result_no_req;
        @(posedge clk_in) disable iff (rst_in)
            load_result.valid |-> !mem_req.valid;
    endproperty

    a_reset_quiet:   assert property (p_reset_quiet) else $error("outputs active in reset");
    a_result_tag:    assert property (p_result_tag) else $error("load result with tag 0");
    a_result_no_req: assert property (p_result_no_req) else $error("request in result cycle");

endmodule

bind lsb_top lsb_assert i_lsb_assert (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .mem_req     (mem_req),
    .load_result (load_result),
    .full        (full)
);

// ==== sim/tb_lsb.sv ====
module tb_lsb import lsb_pkg::*; ();

    localparam int N_OPS     = 60 + 80 + 100 + 100 + LSB_FULL_LEVEL;   // all runs below
    localparam int MAX_CYCLE = N_OPS * 12 + 200;

    typedef struct packed {
        mem_op_t op;
        tag_t    tag;
        word_t   rs1;
        tag_t    t1;
        word_t   rs2;
        tag_t    t2;
        word_t   imm;
        logic    committed;
    } model_t;

    logic              clk_in;
    logic              rst_in;
    dispatch_t         disp;
    bcast_t            alu_bcast;
    logic              store_commit;
    logic              clear;
    logic [BYTE_W-1:0] mem_rdata;
    mem_req_t          mem_req;
    bcast_t            load_result;
    logic              full;

    logic [BYTE_W-1:0] mem [256];
    logic [BYTE_W-1:0] rd_next;
    model_t            mq [$];
    int                wr_idx;
    int                next_tag;
    int                cycle_cnt;
    int                errors;
    int                checks;
    int                tests;

    lsb_top i_lsb_top (.*);

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLE) begin
            @(posedge clk_in);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the queue never drained", cycle_cnt);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic report(string msg);
        errors++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    task automatic check_result(bcast_t got, bcast_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t load_result got tag %0d value %h exp tag %0d value %h",
                     $time, got.tag, got.value, exp.tag, exp.value);
        end
    endtask

    task automatic check_write(mem_req_t got, mem_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t mem_req got addr %h data %h exp addr %h data %h",
                     $time, got.addr, got.wdata, exp.addr, exp.wdata);
        end
    endtask

    function automatic logic is_store(mem_op_t op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

    function automatic int nbytes(mem_op_t op);
        case (op)
            OP_SB:   return 1;
            OP_SH:   return 2;
            default: return 4;
        endcase
    endfunction

    // little-endian fetch, then extend by op
    function automatic word_t load_value(mem_op_t op, word_t addr);
        word_t w;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = mem[8'(addr + 32'(i))];
        end
        case (op)
            OP_LB:   return {{24{w[7]}}, w[7:0]};
            OP_LH:   return {{16{w[15]}}, w[15:0]};
            OP_LBU:  return {24'd0, w[7:0]};
            OP_LHU:  return {16'd0, w[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic model_t wake(model_t m, bcast_t b);
        if (m.t1 != '0 && b.valid && b.tag == m.t1) begin
            m.rs1 = b.value;
            m.t1  = '0;
        end
        if (m.t2 != '0 && b.valid && b.tag == m.t2) begin
            m.rs2 = b.value;
            m.t2  = '0;
        end
        return m;
    endfunction

    // load tags 1..11 stay unique while live, alu owns 12..15
    function automatic tag_t free_tag();
        tag_t t;
        logic busy;
        for (int k = 0; k < 11; k++) begin
            t    = tag_t'(1 + (next_tag + k) % 11);
            busy = 1'b0;
            foreach (mq[i]) begin
                if ((!is_store(mq[i].op) && mq[i].tag == t) || mq[i].t1 == t || mq[i].t2 == t) begin
                    busy = 1'b1;
                end
            end
            if (!busy) begin
                next_tag = next_tag + k + 1;
                return t;
            end
        end
        return '0;
    endfunction

    function automatic tag_t dep_tag();
        int k;
        k = $urandom_range(0, mq.size());
        if (k < mq.size() && !is_store(mq[k].op)) begin
            return mq[k].tag;   // wait on a load still in flight
        end
        return tag_t'($urandom_range(12, 15));
    endfunction

    function automatic dispatch_t make_op(int dep_pct, int st_pct);
        dispatch_t d;
        d         = '0;
        d.valid   = 1'b1;
        d.rs1_val = word_t'($urandom_range(0, 47));   // small window so stores and loads overlap
        d.rs2_val = $urandom;
        d.imm     = word_t'($urandom_range(0, 15)) - 32'd8;
        d.tag     = free_tag();
        if (d.tag == '0 || $urandom_range(0, 99) < st_pct) begin
            d.op  = mem_op_t'($urandom_range(5, 7));
            d.tag = tag_t'($urandom_range(1, 11));
        end else begin
            d.op = mem_op_t'($urandom_range(0, 4));
        end
        if ($urandom_range(0, 99) < dep_pct) begin
            d.rs1_tag = dep_tag();
        end
        if ($urandom_range(0, 99) < dep_pct) begin
            d.rs2_tag = dep_tag();
        end
        return d;
    endfunction

    function automatic logic commit_ok();
        foreach (mq[i]) begin
            if (!mq[i].committed) begin
                return is_store(mq[i].op);
            end
        end
        return 1'b0;
    endfunction

    task automatic observe();
        bcast_t   lexp;
        mem_req_t wexp;
        model_t   keep [$];
        logic     marked;
        lexp   = '0;
        marked = 1'b0;
        check_flag("full", full, mq.size() >= LSB_FULL_LEVEL);
        if (mem_req.valid && !mem_req.write) begin
            rd_next = mem[mem_req.addr[7:0]];
            if (mq.size() == 0 || is_store(mq[0].op)) begin
                report("read request with no load at the head");
            end else if (mq[0].t1 != '0 || mq[0].t2 != '0) begin
                report("read request for a load still waiting on an operand");
            end
        end
        if (mem_req.valid && mem_req.write) begin
            if (mq.size() == 0 || !is_store(mq[0].op) || !mq[0].committed) begin
                report("write request with no committed store at the head");
            end else begin
                if (mq[0].t1 != '0 || mq[0].t2 != '0) begin
                    report("write request for a store still waiting on an operand");
                end
                wexp.valid = 1'b1;
                wexp.write = 1'b1;
                wexp.addr  = mq[0].rs1 + mq[0].imm + word_t'(wr_idx);
                wexp.wdata = mq[0].rs2[8*wr_idx +: 8];
                check_write(mem_req, wexp);
                mem[wexp.addr[7:0]] = wexp.wdata;
                wr_idx++;
                if (wr_idx == nbytes(mq[0].op)) begin
                    wr_idx = 0;
                    void'(mq.pop_front());
                end
            end
        end
        if (load_result.valid) begin
            if (mq.size() == 0 || is_store(mq[0].op)) begin
                report("load result with no load at the head");
            end else begin
                lexp.valid = 1'b1;
                lexp.tag   = mq[0].tag;
                lexp.value = load_value(mq[0].op, mq[0].rs1 + mq[0].imm);
                check_result(load_result, lexp);
                void'(mq.pop_front());
            end
        end
        if (disp.valid && !clear) begin
            mq.push_back('{disp.op, disp.tag, disp.rs1_val, disp.rs1_tag,
                           disp.rs2_val, disp.rs2_tag, disp.imm, 1'b0});
        end
        foreach (mq[i]) begin
            mq[i] = wake(wake(mq[i], alu_bcast), lexp);   // new entry too, as a bypass
        end
        if (clear) begin
            foreach (mq[i]) begin
                if (mq[i].committed) begin
                    keep.push_back(mq[i]);
                end
            end
            mq = keep;
        end else if (store_commit) begin
            foreach (mq[i]) begin
                if (!mq[i].committed && !marked) begin
                    mq[i].committed = 1'b1;
                    marked          = 1'b1;
                end
            end
        end
    endtask

    task automatic drive_cycle(dispatch_t d, bcast_t a, logic commit, logic clr);
        @(negedge clk_in);
        disp         = d;
        alu_bcast    = a;
        store_commit = commit;
        clear        = clr;
        mem_rdata    = rd_next;   // read from the previous cycle
        #1;
        observe();
    endtask

    task automatic finish_test(string name, int err0);
        tests++;
        $display("test %-8s %s, %0d errors", name, (errors == err0) ? "ok" : "failed",
                 errors - err0);
    endtask

    // hold keeps stores uncommitted until every op is in
    task automatic run(string name, int n_ops, int dep_pct, int st_pct, int clr_pct, logic hold);
        int        sent;
        int        err0;
        dispatch_t d;
        bcast_t    a;
        logic      cm;
        logic      cl;
        sent = 0;
        err0 = errors;
        while (sent < n_ops || mq.size() != 0) begin
            d  = '0;
            a  = '0;
            cl = sent < n_ops && $urandom_range(0, 99) < clr_pct;
            if (!cl && sent < n_ops && mq.size() < LSB_FULL_LEVEL && $urandom_range(0, 1)) begin
                d = make_op(dep_pct, st_pct);
                sent++;
            end
            if ($urandom_range(0, 2) == 0 || sent >= n_ops) begin
                a = '{1'b1, tag_t'($urandom_range(12, 15)), word_t'($urandom)};
            end
            cm = !cl && commit_ok() && !(hold && sent < n_ops) &&
                 ($urandom_range(0, 1) || sent >= n_ops);
            drive_cycle(d, a, cm, cl);
        end
        repeat (4) drive_cycle('0, '0, 1'b0, 1'b0);   // nothing more may come out
        finish_test(name, err0);
    endtask

    initial begin
        void'($urandom(32'h730c2ec8));
        errors       = 0;
        checks       = 0;
        tests        = 0;
        wr_idx       = 0;
        next_tag     = 0;
        rd_next      = '0;
        rst_in       = 1'b1;
        disp         = '0;
        alu_bcast    = '0;
        store_commit = 1'b0;
        clear        = 1'b0;
        mem_rdata    = '0;
        for (int a = 0; a < 256; a++) begin
            mem[a] = 8'(a * 97 + (a >> 4) * 13 + 5);
        end
        repeat (4) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;
        #1;
        check_flag("mem_req.valid", mem_req.valid, 1'b0);
        check_flag("load_result.valid", load_result.valid, 1'b0);
        check_flag("full", full, 1'b0);
        finish_test("reset", 0);
        run("loads", 60, 0, 0, 0, 1'b0);
        run("stores", 80, 0, 50, 0, 1'b0);
        run("deps", 100, 40, 30, 0, 1'b0);
        run("clear", 100, 30, 40, 4, 1'b0);
        run("full", LSB_FULL_LEVEL, 0, 100, 0, 1'b1);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
source/lsb_pkg.sv
source/operand_capture.sv
source/lsb_queue.sv
source/mem_sequencer.sv
source/lsb_top.sv
sim/lsb_assert.sv
sim/tb_lsb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_lsb
FILELIST  = sources.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
